// File: src.f
dbus_pkg.sv
dbus_port_if.sv
dbus_dtm_port.sv
dbus_arb_core.sv
dbus_dm_port.sv
dbus_arbiter.sv
tb_dbus_arbiter.sv

// File: Makefile
# Verilator build and run of the DBus arbiter testbench.
# Any variable can be overridden on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_dbus_arbiter
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_dbus_arbiter.sv
// Testbench for the DBus arbiter.
// Models NUM_DTM transport modules and one debug module with four-phase
// handshakes and random ack delays, applies a table of rounds and checks
// grant order, payloads and response routing.
`timescale 1ns/1ps
`default_nettype none

module tb_dbus_arbiter;
    import dbus_pkg::*;

    localparam int          CLK_PERIOD  = 100;
    localparam int          DRIVE_DELAY = 10;
    localparam int          NUM_ROWS    = 8;
    localparam int          MAX_CYCLES  = 400 * NUM_ROWS;
    localparam logic [31:0] SEED        = 32'd84;

    logic               clk;
    logic               rst_n;
    logic [NUM_DTM-1:0] dtm_req_req;
    logic [NUM_DTM-1:0] dtm_req_ack;
    dbus_req_t          dtm_req_bits [NUM_DTM];
    logic [NUM_DTM-1:0] dtm_rsp_req;
    logic [NUM_DTM-1:0] dtm_rsp_ack;
    dbus_rsp_t          dtm_rsp_bits [NUM_DTM];
    logic               dm_req_req;
    logic               dm_req_ack;
    dbus_req_t          dm_req_bits;
    logic               dm_rsp_req;
    logic               dm_rsp_ack;
    dbus_rsp_t          dm_rsp_bits;

    // stimulus table with one row per round
    logic [NUM_DTM-1:0] row_mask [NUM_ROWS];
    dbus_req_t          row_req  [NUM_ROWS][NUM_DTM];
    dbus_rsp_t          row_rsp  [NUM_ROWS];
    logic               row_slow [NUM_ROWS];

    // expected grant order and bookkeeping shared by the models
    int                 exp_order [$];
    int                 model_last;
    logic [NUM_DTM-1:0] dm_req_closed;
    int                 rsp_owner;
    logic [31:0]        rng;

    int errors;
    int mon_errors;
    int checks;
    int cycles;
    int failed_tests;

    dbus_arbiter dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .dtm_req_req_i  (dtm_req_req),
        .dtm_req_ack_o  (dtm_req_ack),
        .dtm_req_bits_i (dtm_req_bits),
        .dtm_rsp_req_o  (dtm_rsp_req),
        .dtm_rsp_ack_i  (dtm_rsp_ack),
        .dtm_rsp_bits_o (dtm_rsp_bits),
        .dm_req_req_o   (dm_req_req),
        .dm_req_ack_i   (dm_req_ack),
        .dm_req_bits_o  (dm_req_bits),
        .dm_rsp_req_i   (dm_rsp_req),
        .dm_rsp_ack_o   (dm_rsp_ack),
        .dm_rsp_bits_i  (dm_rsp_bits)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers and compare tasks
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // short delays normally, long ones in slow rounds
    function automatic int rand_delay(input logic slow);
        rng = xorshift32(rng);
        if (slow) begin
            return 8 + int'(rng % 32'd16);
        end else begin
            return int'(rng % 32'd4);
        end
    endfunction

    // outputs are stable here and inputs change away from the edge
    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%0t: %s", $time, what);
    endtask

    task automatic check_req(input string name, input dbus_req_t exp, input dbus_req_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_rsp(input string name, input dbus_rsp_t exp, input dbus_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input dtm_idx_t exp, input dtm_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%-24s ok", name);
        end else begin
            failed_tests++;
            $display("%-24s %0d errors", name, errors - err_before);
        end
    endtask

    task automatic set_row(input int r, input logic [NUM_DTM-1:0] mask, input dbus_req_t req0,
                           input dbus_req_t req1, input dbus_req_t req2, input dbus_rsp_t rsp,
                           input logic slow);
        row_mask[r]   = mask;
        row_req[r][0] = req0;
        row_req[r][1] = req1;
        row_req[r][2] = req2;
        row_rsp[r]    = rsp;
        row_slow[r]   = slow;
    endtask

    task automatic fill_table();
        // single ports first and then groups
        // slow rounds stretch the DTM acks
        set_row(0, 3'b001, 41'h001_0000_1111, 41'h0, 41'h0, 36'h1_0000_00a1, 1'b0);
        set_row(1, 3'b010, 41'h0, 41'h0a2_1234_5678, 41'h0, 36'h2_dead_beef, 1'b0);
        set_row(2, 3'b100, 41'h0, 41'h0, 41'h1ff_ffff_fffe, 36'h3_cafe_0003, 1'b0);
        set_row(3, 3'b111, 41'h013_0000_0001, 41'h023_0000_0002, 41'h033_0000_0003,
                36'h4_0404_0404, 1'b0);
        set_row(4, 3'b101, 41'h104_aaaa_5555, 41'h0, 41'h124_5555_aaaa, 36'h5_5a5a_a5a5, 1'b0);
        set_row(5, 3'b011, 41'h015_1357_9bdf, 41'h025_2468_ace0, 41'h0, 36'h6_0f0f_f0f0, 1'b1);
        set_row(6, 3'b111, 41'h016_0000_0a0a, 41'h026_0000_0b0b, 41'h036_0000_0c0c,
                36'h7_7777_7777, 1'b1);
        set_row(7, 3'b110, 41'h0, 41'h027_8000_0001, 41'h037_4000_0002, 36'h8_1234_4321, 1'b0);
    endtask

    // rotating priority searches from the port after the last one served
    task automatic build_order(input logic [NUM_DTM-1:0] mask);
        int cand;
        for (int off = 1; off <= NUM_DTM; off++) begin
            cand = (model_last + off) % NUM_DTM;
            if (mask[cand]) begin
                exp_order.push_back(cand);
            end
        end
        if (mask != '0) begin
            model_last = exp_order[$];
        end
    endtask

    // index of the one port whose request ack is high or all ones if there is none
    function automatic dtm_idx_t acked_port(input logic [NUM_DTM-1:0] acks);
        dtm_idx_t idx;
        int       hits;
        idx  = '1;
        hits = 0;
        for (int i = 0; i < NUM_DTM; i++) begin
            if (acks[i]) begin
                idx = dtm_idx_t'(i);
                hits++;
            end
        end
        if (hits != 1) begin
            idx = '1;
        end
        return idx;
    endfunction

    // ------------------------------------------------------------------------
    // handshake models
    // ------------------------------------------------------------------------

    // one DTM request followed by its response
    task automatic dtm_txn(input int p, input int r);
        dtm_req_bits[p] = row_req[r][p];
        dtm_req_req[p]  = 1'b1;
        while (!dtm_req_ack[p]) tick();
        repeat (rand_delay(row_slow[r])) tick();
        dtm_req_req[p] = 1'b0;
        while (dtm_req_ack[p]) tick();
        // ack must outlast the DM request handshake
        if (!dm_req_closed[p]) begin
            report_failure($sformatf("port %0d request ack fell before the DM request ack", p));
        end
        while (!dtm_rsp_req[p]) tick();
        check_rsp($sformatf("dtm_rsp_bits[%0d]", p), row_rsp[r] ^ dbus_rsp_t'(p),
                  dtm_rsp_bits[p]);
        repeat (rand_delay(row_slow[r])) tick();
        dtm_rsp_ack[p] = 1'b1;
        while (dtm_rsp_req[p]) tick();
        repeat (rand_delay(row_slow[r])) tick();
        dtm_rsp_ack[p] = 1'b0;
    endtask

    // DM side serves n transactions, checks order and forwarded payload
    task automatic dm_txns(input int r, input int n);
        int       exp;
        dtm_idx_t act;
        for (int k = 0; k < n; k++) begin
            while (!dm_req_req) tick();
            exp = exp_order.pop_front();
            act = acked_port(dtm_req_ack);
            check_idx("dtm_req_ack index", dtm_idx_t'(exp), act);
            check_req("dm_req_bits", row_req[r][exp], dm_req_bits);
            repeat (rand_delay(1'b0)) tick();
            dm_req_ack = 1'b1;
            while (dm_req_req) tick();
            repeat (rand_delay(1'b0)) tick();
            dm_req_ack = 1'b0;
            dm_req_closed[exp] = 1'b1;
            repeat (rand_delay(1'b0)) tick();
            rsp_owner   = exp;
            dm_rsp_bits = row_rsp[r] ^ dbus_rsp_t'(exp);
            dm_rsp_req  = 1'b1;
            while (!dm_rsp_ack) tick();
            repeat (rand_delay(1'b0)) tick();
            dm_rsp_req = 1'b0;
            while (dm_rsp_ack) tick();
        end
    endtask

    // ------------------------------------------------------------------------
    // protocol monitor
    // ------------------------------------------------------------------------

    logic               dm_busy;
    logic               dm_req_prev;
    logic               dm_ack_prev;
    logic [NUM_DTM-1:0] rsp_req_prev;

    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_DTM; p++) begin
                if (dtm_rsp_req[p] && !rsp_req_prev[p] && p != rsp_owner) begin
                    mon_errors++;
                    $display("%0t: response req rose on port %0d, owner is %0d",
                             $time, p, rsp_owner);
                end
            end
            // no second DM request while a response is still open
            if (dm_req_req && !dm_req_prev) begin
                if (dm_busy) begin
                    mon_errors++;
                    $display("%0t: DM request rose before the last response closed", $time);
                end
                dm_busy = 1'b1;
            end
            if (!dm_rsp_ack && dm_ack_prev) begin
                dm_busy = 1'b0;
            end
        end
        dm_req_prev  = dm_req_req;
        dm_ack_prev  = dm_rsp_ack;
        rsp_req_prev = dtm_rsp_req;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a handshake never completed", cycles);
        $display(">>> FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin : main
        int n_req;
        int err_before;
        rst_n         = 1'b0;
        dtm_req_req   = '0;
        dtm_rsp_ack   = '0;
        dm_req_ack    = 1'b0;
        dm_rsp_req    = 1'b0;
        dm_rsp_bits   = '0;
        dm_req_closed = '0;
        rsp_owner     = -1;
        dm_busy       = 1'b0;
        errors        = 0;
        mon_errors    = 0;
        checks        = 0;
        failed_tests  = 0;
        rng           = SEED;
        model_last    = NUM_DTM - 1;
        for (int p = 0; p < NUM_DTM; p++) begin
            dtm_req_bits[p] = '0;
        end
        fill_table();
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        err_before = errors;
        check_bit("dm_req_req", 1'b0, dm_req_req);
        check_bit("dm_rsp_ack", 1'b0, dm_rsp_ack);
        for (int p = 0; p < NUM_DTM; p++) begin
            check_bit($sformatf("dtm_req_ack[%0d]", p), 1'b0, dtm_req_ack[p]);
            check_bit($sformatf("dtm_rsp_req[%0d]", p), 1'b0, dtm_rsp_req[p]);
        end
        report_test("reset", err_before);

        for (int r = 0; r < NUM_ROWS; r++) begin
            err_before    = errors + mon_errors;
            build_order(row_mask[r]);
            n_req         = $countones(row_mask[r]);
            dm_req_closed = '0;
            tick();
            for (int p = 0; p < NUM_DTM; p++) begin
                if (row_mask[r][p]) begin
                    fork
                        automatic int pp = p;
                        dtm_txn(pp, r);
                    join_none
                end
            end
            dm_txns(r, n_req);
            wait fork;
            // a stray grant would raise dm_req_req one cycle after the state reopens
            repeat (2) tick();
            check_bit("dm_req_req", 1'b0, dm_req_req);
            errors = errors + mon_errors;
            mon_errors = 0;
            report_test($sformatf("row %0d mask %b", r, row_mask[r]), err_before);
        end

        errors = errors + mon_errors;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_ROWS + 1, failed_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_dbus_arbiter

`default_nettype wire

// File: dbus_arbiter.sv
// Top level of the DBus arbiter: NUM_DTM debug transport modules share
// one debug module over four-phase req/ack links.
// All handshake inputs are synchronized, so each side may use its own clock.
`timescale 1ns/1ps
`default_nettype none

module dbus_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    // DTM links, one entry per port
    input  logic [dbus_pkg::NUM_DTM-1:0] dtm_req_req_i,
    output logic [dbus_pkg::NUM_DTM-1:0] dtm_req_ack_o,
    input  dbus_pkg::dbus_req_t          dtm_req_bits_i [dbus_pkg::NUM_DTM],
    output logic [dbus_pkg::NUM_DTM-1:0] dtm_rsp_req_o,
    input  logic [dbus_pkg::NUM_DTM-1:0] dtm_rsp_ack_i,
    output dbus_pkg::dbus_rsp_t          dtm_rsp_bits_o [dbus_pkg::NUM_DTM],
    // DM link
    output logic                         dm_req_req_o,
    input  logic                         dm_req_ack_i,
    output dbus_pkg::dbus_req_t          dm_req_bits_o,
    input  logic                         dm_rsp_req_i,
    output logic                         dm_rsp_ack_o,
    input  dbus_pkg::dbus_rsp_t          dm_rsp_bits_i
);
    import dbus_pkg::*;

    dbus_port_if port_if [NUM_DTM] ();

    logic      dm_rsp_valid;
    logic      dm_rsp_fall;
    logic      rsp_accept;
    logic      rsp_done_sel;
    dtm_idx_t  grant_idx;
    // captured DM response, fanned out to all DTM ports
    dbus_rsp_t rsp_bits;

    // identical DTM side ports
    for (genvar g = 0; g < NUM_DTM; g++) begin : g_dtm
        dbus_dtm_port dtm_port_i (
            .clk            (clk),
            .rst_n          (rst_n),
            .dtm_req_req_i  (dtm_req_req_i[g]),
            .dtm_req_ack_o  (dtm_req_ack_o[g]),
            .dtm_req_bits_i (dtm_req_bits_i[g]),
            .dtm_rsp_req_o  (dtm_rsp_req_o[g]),
            .dtm_rsp_ack_i  (dtm_rsp_ack_i[g]),
            .dtm_rsp_bits_o (dtm_rsp_bits_o[g]),
            .rsp_bits_i     (rsp_bits),
            .port_o         (port_if[g])
        );
    end

    dbus_arb_core core_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ports_o        (port_if),
        .dm_rsp_valid_i (dm_rsp_valid),
        .dm_rsp_fall_i  (dm_rsp_fall),
        .rsp_accept_o   (rsp_accept),
        .grant_idx_o    (grant_idx),
        .rsp_done_sel_o (rsp_done_sel)
    );

    dbus_dm_port dm_port_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ports_i        (port_if),
        .grant_idx_i    (grant_idx),
        .rsp_accept_i   (rsp_accept),
        .rsp_done_sel_i (rsp_done_sel),
        .dm_rsp_valid_o (dm_rsp_valid),
        .dm_rsp_fall_o  (dm_rsp_fall),
        .rsp_bits_o     (rsp_bits),
        .dm_req_req_o   (dm_req_req_o),
        .dm_req_ack_i   (dm_req_ack_i),
        .dm_req_bits_o  (dm_req_bits_o),
        .dm_rsp_req_i   (dm_rsp_req_i),
        .dm_rsp_ack_o   (dm_rsp_ack_o),
        .dm_rsp_bits_i  (dm_rsp_bits_i)
    );

endmodule : dbus_arbiter

`default_nettype wire

// File: dbus_dm_port.sv
// DM-facing port of the DBus arbiter.
// Registers the granted request and drives the DM request channel, then
// captures the DM response and holds its ack until the DTM side is done.
`timescale 1ns/1ps
`default_nettype none

module dbus_dm_port (
    input  logic                clk,
    input  logic                rst_n,
    dbus_port_if.dm_mp          ports_i [dbus_pkg::NUM_DTM],
    // from the core
    input  dbus_pkg::dtm_idx_t  grant_idx_i,
    input  logic                rsp_accept_i,
    input  logic                rsp_done_sel_i,
    // to the core and the DTM ports
    output logic                dm_rsp_valid_o,
    output logic                dm_rsp_fall_o,
    output dbus_pkg::dbus_rsp_t rsp_bits_o,
    // DM request channel
    output logic                dm_req_req_o,
    input  logic                dm_req_ack_i,
    output dbus_pkg::dbus_req_t dm_req_bits_o,
    // DM response channel
    input  logic                dm_rsp_req_i,
    output logic                dm_rsp_ack_o,
    input  dbus_pkg::dbus_rsp_t dm_rsp_bits_i
);
    import dbus_pkg::*;

    dbus_req_t          bits_arr [NUM_DTM];
    logic [NUM_DTM-1:0] grant_vec;
    logic               grant_any;
    // port whose request sits in the DM request register
    dtm_idx_t           owner_q;

    logic [SYNC_STAGES-1:0] ack_sync_q;
    logic [SYNC_STAGES-1:0] rsp_sync_q;
    logic                   ack_sync;
    logic                   ack_d;
    logic                   ack_fall;
    // holds the DM response req up until the DTM response is done
    logic                   rsp_pend_q;
    logic                   rsp_int;
    logic                   rsp_int_d;

    for (genvar i = 0; i < NUM_DTM; i++) begin : g_port
        assign bits_arr[i]          = ports_i[i].req_bits;
        assign grant_vec[i]         = ports_i[i].grant;
        assign ports_i[i].req_taken = ack_fall && (owner_q == dtm_idx_t'(i));
    end

    assign grant_any = |grant_vec;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_sync_q <= '0;
            rsp_sync_q <= '0;
            ack_d      <= 1'b0;
            rsp_int_d  <= 1'b0;
        end else begin
            ack_sync_q <= {ack_sync_q[SYNC_STAGES-2:0], dm_req_ack_i};
            rsp_sync_q <= {rsp_sync_q[SYNC_STAGES-2:0], dm_rsp_req_i};
            ack_d      <= ack_sync;
            rsp_int_d  <= rsp_int;
        end
    end

    assign ack_sync = ack_sync_q[SYNC_STAGES-1];
    assign ack_fall = ack_d & ~ack_sync;

    // ------------------------------------------------------------------------
    // request path
    // ------------------------------------------------------------------------

    // payload captured in the grant cycle
    always_ff @(posedge clk) begin
        if (grant_any) begin
            dm_req_bits_o <= bits_arr[grant_idx_i];
        end
    end

    // req rises the cycle after the grant, drops on the synchronized ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q      <= '0;
            dm_req_req_o <= 1'b0;
        end else if (grant_any) begin
            owner_q      <= grant_idx_i;
            dm_req_req_o <= 1'b1;
        end else if (dm_req_req_o && ack_sync) begin
            dm_req_req_o <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // response path
    // ------------------------------------------------------------------------

    assign rsp_int        = rsp_sync_q[SYNC_STAGES-1] | rsp_pend_q;
    assign dm_rsp_valid_o = rsp_int & ~dm_rsp_ack_o;
    assign dm_rsp_fall_o  = rsp_int_d & ~rsp_int;

    // shared response register, read by every DTM port
    always_ff @(posedge clk) begin
        if (rsp_accept_i) begin
            rsp_bits_o <= dm_rsp_bits_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dm_rsp_ack_o <= 1'b0;
            rsp_pend_q   <= 1'b0;
        end else begin
            if (rsp_accept_i) begin
                dm_rsp_ack_o <= 1'b1;
            end else if (dm_rsp_fall_o) begin
                dm_rsp_ack_o <= 1'b0;
            end
            if (rsp_accept_i) begin
                rsp_pend_q <= 1'b1;
            end else if (rsp_done_sel_i) begin
                rsp_pend_q <= 1'b0;
            end
        end
    end

    // a new grant only once the previous DM request and response are closed
    a_grant_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) grant_any |-> !dm_req_req_o && !dm_rsp_ack_o
    );

endmodule : dbus_dm_port

`default_nettype wire

// File: dbus_arb_core.sv
// Arbitration core of the DBus arbiter.
// Grants one pending DTM port at a time in rotating order and tracks the
// request/response transaction until the DM response has been handed back.
`timescale 1ns/1ps
`default_nettype none

module dbus_arb_core (
    input  logic               clk,
    input  logic               rst_n,
    dbus_port_if.core_mp       ports_o [dbus_pkg::NUM_DTM],
    // DM response status from the DM port
    input  logic               dm_rsp_valid_i,
    input  logic               dm_rsp_fall_i,
    // to the DM port
    output logic               rsp_accept_o,
    output dbus_pkg::dtm_idx_t grant_idx_o,
    output logic               rsp_done_sel_o
);
    import dbus_pkg::*;

    logic [NUM_DTM-1:0] pend_vec;
    logic [NUM_DTM-1:0] done_vec;
    logic [NUM_DTM-1:0] grant_vec;
    logic [NUM_DTM-1:0] start_vec;

    trans_state_t state_q;
    trans_state_t state_d;
    // port served last, search starts right after it
    dtm_idx_t     last_q;
    dtm_idx_t     pick;
    logic         found;
    logic         grant_any;

    // flatten the interface array into vectors
    for (genvar i = 0; i < NUM_DTM; i++) begin : g_port
        assign pend_vec[i]         = ports_o[i].req_pend;
        assign done_vec[i]         = ports_o[i].rsp_done;
        assign ports_o[i].grant     = grant_vec[i];
        assign ports_o[i].rsp_start = start_vec[i];
    end

    // ------------------------------------------------------------------------
    // rotating priority
    // ------------------------------------------------------------------------

    // first pending port from last+1, wrapping around
    always_comb begin : p_pick
        int cand;
        found = 1'b0;
        pick  = last_q;
        for (int off = 1; off <= NUM_DTM; off++) begin
            cand = (int'(last_q) + off) % NUM_DTM;
            if (!found && pend_vec[cand]) begin
                found = 1'b1;
                pick  = dtm_idx_t'(cand);
            end
        end
    end

    // grants only while no transaction is outstanding
    assign grant_any   = (state_q == Q_REQ) & found;
    assign grant_idx_o = pick;

    always_comb begin : p_strobes
        for (int i = 0; i < NUM_DTM; i++) begin
            grant_vec[i] = grant_any && (pick == dtm_idx_t'(i));
            start_vec[i] = rsp_accept_o && (last_q == dtm_idx_t'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= dtm_idx_t'(NUM_DTM - 1);
        end else if (grant_any) begin
            last_q <= pick;
        end
    end

    // ------------------------------------------------------------------------
    // transaction FSM
    // ------------------------------------------------------------------------

    always_comb begin : p_next
        state_d = state_q;
        case (state_q)
            Q_REQ: if (grant_any) state_d = Q_RSP;
            Q_RSP: if (dm_rsp_fall_i) state_d = Q_REQ;
            default: state_d = Q_REQ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= Q_REQ;
        end else begin
            state_q <= state_d;
        end
    end

    // response goes back to the port that was granted last
    assign rsp_accept_o   = (state_q == Q_RSP) & dm_rsp_valid_i;
    assign rsp_done_sel_o = done_vec[last_q];

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(grant_vec)
    );
    a_no_grant_in_rsp: assert property (
        @(posedge clk) disable iff (!rst_n) (state_q == Q_RSP) |-> (grant_vec == '0)
    );

endmodule : dbus_arb_core

`default_nettype wire

// File: dbus_dtm_port.sv
// One DTM-facing port of the DBus arbiter.
// Synchronizes the DTM request and response ack, holds the request ack
// until the DM side has taken the request, and drives the DTM response req.
`timescale 1ns/1ps
`default_nettype none

module dbus_dtm_port (
    input  logic                clk,
    input  logic                rst_n,
    // DTM request channel
    input  logic                dtm_req_req_i,
    output logic                dtm_req_ack_o,
    input  dbus_pkg::dbus_req_t dtm_req_bits_i,
    // DTM response channel
    output logic                dtm_rsp_req_o,
    input  logic                dtm_rsp_ack_i,
    output dbus_pkg::dbus_rsp_t dtm_rsp_bits_o,
    // shared response payload from the DM port
    input  dbus_pkg::dbus_rsp_t rsp_bits_i,
    dbus_port_if.dtm_mp         port_o
);
    import dbus_pkg::*;

    // synchronizer chains, last stage is the usable one
    logic [SYNC_STAGES-1:0] req_sync_q;
    logic [SYNC_STAGES-1:0] rsp_ack_sync_q;
    logic                   req_sync;
    logic                   rsp_ack_sync;

    // keeps the internal request up until the DM has taken it
    logic req_pend_q;
    // internal request and its delayed copy for fall detection
    logic req_int;
    logic req_int_d;
    logic req_fall;
    logic rsp_ack_d;

    // ------------------------------------------------------------------------
    // request channel
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_sync_q     <= '0;
            rsp_ack_sync_q <= '0;
        end else begin
            req_sync_q     <= {req_sync_q[SYNC_STAGES-2:0], dtm_req_req_i};
            rsp_ack_sync_q <= {rsp_ack_sync_q[SYNC_STAGES-2:0], dtm_rsp_ack_i};
        end
    end

    assign req_sync     = req_sync_q[SYNC_STAGES-1];
    assign rsp_ack_sync = rsp_ack_sync_q[SYNC_STAGES-1];

    // DTM request ORed with the pending flag
    assign req_int  = req_sync | req_pend_q;
    assign req_fall = req_int_d & ~req_int;

    // masked by ack so a request still held up is not granted twice
    assign port_o.req_pend = req_int & ~dtm_req_ack_o;
    assign port_o.req_bits = dtm_req_bits_i;

    // ack rises on grant, falls once both the DTM req and the pending flag
    // have gone, i.e. after the DM request handshake finished
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dtm_req_ack_o <= 1'b0;
        end else if (port_o.grant) begin
            dtm_req_ack_o <= 1'b1;
        end else if (req_fall) begin
            dtm_req_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_pend_q <= 1'b0;
        end else if (port_o.grant) begin
            req_pend_q <= 1'b1;
        end else if (port_o.req_taken) begin
            req_pend_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // response channel
    // ------------------------------------------------------------------------

    // response req set by the core, cleared by the synchronized ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dtm_rsp_req_o <= 1'b0;
        end else if (port_o.rsp_start) begin
            dtm_rsp_req_o <= 1'b1;
        end else if (dtm_rsp_req_o && rsp_ack_sync) begin
            dtm_rsp_req_o <= 1'b0;
        end
    end

    // delayed copies for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_int_d <= 1'b0;
            rsp_ack_d <= 1'b0;
        end else begin
            req_int_d <= req_int;
            rsp_ack_d <= rsp_ack_sync;
        end
    end

    // ack fall ends the DTM response handshake
    assign port_o.rsp_done = rsp_ack_d & ~rsp_ack_sync;

    // payload register lives in the DM port and is shared by all ports
    assign dtm_rsp_bits_o = rsp_bits_i;

    // the core must never grant a port still in the middle of a handshake
    a_no_grant_while_ack: assert property (
        @(posedge clk) disable iff (!rst_n) port_o.grant |-> !dtm_req_ack_o
    );

endmodule : dbus_dtm_port

`default_nettype wire

// File: dbus_port_if.sv
// Link between one DTM port and the arbitration core and DM port.
// One instance per DTM; the core and the DM port see the whole array.
`timescale 1ns/1ps
`default_nettype none

interface dbus_port_if;
    import dbus_pkg::*;

    // request waiting for a grant (synchronized req or pending flag)
    logic      req_pend;
    // request payload straight from the DTM
    dbus_req_t req_bits;
    // strobe, this port's request is accepted
    logic      grant;
    // strobe, the response being captured belongs to this port
    logic      rsp_start;
    // strobe, synchronized response ack of this port fell
    logic      rsp_done;
    // strobe, DM request ack fell, request handed over
    logic      req_taken;

    // DTM side
    modport dtm_mp (
        output req_pend, req_bits, rsp_done,
        input  grant, rsp_start, req_taken
    );

    // arbitration core
    modport core_mp (
        input  req_pend, rsp_done,
        output grant, rsp_start
    );

    // DM side, takes the granted payload
    modport dm_mp (
        input  req_bits, grant,
        output req_taken
    );

endinterface : dbus_port_if

`default_nettype wire

// File: dbus_pkg.sv
// Shared definitions for the multi-port DBus arbiter.
// Holds the port count, payload widths, synchronizer depth and the
// transaction state encoding used by the core.
`default_nettype none

package dbus_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------

    // number of DTM ports sharing the one DM
    localparam int NUM_DTM = 3;
    // width of a DTM port index
    localparam int DTM_IDX_W = 2;

    // request payload: address, data and op
    localparam int DBUS_REQ_BITS = 41;
    // response payload: data and status
    localparam int DBUS_RSP_BITS = 36;

    // flops on every incoming handshake signal
    localparam int SYNC_STAGES = 2;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------

    typedef logic [DBUS_REQ_BITS-1:0] dbus_req_t;
    typedef logic [DBUS_RSP_BITS-1:0] dbus_rsp_t;
    typedef logic [DTM_IDX_W-1:0]     dtm_idx_t;

    // transaction tracking
    // a request is followed by exactly one response before the next grant
    typedef enum logic {
        // open for a new request from any port
        Q_REQ = 1'b0,
        // transaction outstanding, waiting for the DM response
        Q_RSP = 1'b1
    } trans_state_t;

endpackage : dbus_pkg

`default_nettype wire
